//--- Makefile
SRCS := $(shell cat sources.f)

.PHONY: run clean

obj_dir/Vtb_pipeline: sources.f $(SRCS)
	verilator --binary --timing --assert -f sources.f --top-module tb_pipeline -Mdir obj_dir

run: obj_dir/Vtb_pipeline
	@out="$$(./obj_dir/Vtb_pipeline)"; echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

//--- ex.sv
`timescale 1ns/1ps

module ex (
  input  logic             clock,
  input  logic             reset_i,
  input  logic             mem_stall_i,
  input  pip_pkg::id_ex_t  id_ex_i,
  input  pip_pkg::mem_wb_t mem_wb_i,
  output pip_pkg::ex_mem_t ex_mem_o
);

  import pip_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_y;
  ex_mem_t         ex_mem_d;

  function automatic logic [XLEN-1:0] fwd_mux(
    input fwd_t            sel,
    input logic [XLEN-1:0] reg_val,
    input logic [XLEN-1:0] ex_mem_val,
    input logic [XLEN-1:0] mem_wb_val
  );
    logic [XLEN-1:0] val;
    case (sel)
      FWD_EX_MEM: val = ex_mem_val;
      FWD_MEM_WB: val = mem_wb_val;
      default:    val = reg_val;
    endcase
    return val;
  endfunction

  assign op_a  = fwd_mux(id_ex_i.a_fwd, id_ex_i.a, ex_mem_o.result, mem_wb_i.result);
  assign op_b  = fwd_mux(id_ex_i.b_fwd, id_ex_i.b, ex_mem_o.result, mem_wb_i.result);
  assign alu_b = id_ex_i.imm_valid ? id_ex_i.imm : op_b;

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_SUB: alu_y = op_a - alu_b;
      ALU_AND: alu_y = op_a & alu_b;
      ALU_OR:  alu_y = op_a | alu_b;
      ALU_XOR: alu_y = op_a ^ alu_b;
      ALU_SLT: alu_y = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
      default: alu_y = op_a + alu_b;
    endcase
  end

  // Store data is the forwarded B, not the immediate
  assign ex_mem_d.valid      = id_ex_i.valid;
  assign ex_mem_d.result     = alu_y;
  assign ex_mem_d.store_data = op_b;
  assign ex_mem_d.load       = id_ex_i.load;
  assign ex_mem_d.store      = id_ex_i.store;
  assign ex_mem_d.dest       = id_ex_i.dest;
  assign ex_mem_d.dest_valid = id_ex_i.dest_valid;

  pipe_stage_reg #(
    .payload_t (ex_mem_t)
  ) ex_mem_reg (
    .clock    (clock),
    .reset_i  (reset_i),
    .hold_i   (mem_stall_i),
    .bubble_i (1'b0),
    .d_i      (ex_mem_d),
    .q_o      (ex_mem_o)
  );

endmodule

//--- idec.sv
`timescale 1ns/1ps

module idec (
  input  logic                           clock,
  input  logic                           reset_i,
  input  logic                           mem_stall_i,
  input  pip_pkg::if_id_t                if_id_i,
  input  pip_pkg::ex_mem_t               ex_mem_i,
  output logic [pip_pkg::REG_ADDR_W-1:0] rfile_rd_addr1_o,
  output logic [pip_pkg::REG_ADDR_W-1:0] rfile_rd_addr2_o,
  input  logic [pip_pkg::XLEN-1:0]       rfile_rd_data1_i,
  input  logic [pip_pkg::XLEN-1:0]       rfile_rd_data2_i,
  output logic                           id_stall_o,
  output pip_pkg::id_ex_t                id_ex_o
);

  import pip_pkg::*;

  logic [5:0]            opc;
  logic [5:0]            funct;
  logic [REG_ADDR_W-1:0] rs;
  logic [REG_ADDR_W-1:0] rt;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm_sext;
  logic [XLEN-1:0]       imm_zext;

  alu_op_t               alu_op;
  logic [XLEN-1:0]       imm;
  logic                  imm_valid;
  logic                  load;
  logic                  store;
  logic                  a_used;
  logic                  b_used;
  logic [REG_ADDR_W-1:0] dest;
  logic                  dest_ok;
  logic                  load_use;
  id_ex_t                id_ex_d;

  function automatic fwd_t fwd_sel(
    input logic                  used,
    input logic [REG_ADDR_W-1:0] src,
    input logic                  near_wr,
    input logic [REG_ADDR_W-1:0] near_dest,
    input logic                  far_wr,
    input logic [REG_ADDR_W-1:0] far_dest
  );
    fwd_t sel;
    sel = FWD_NONE;
    if (used && src != '0) begin
      // Younger producer wins
      if (near_wr && near_dest == src) begin
        sel = FWD_EX_MEM;
      end else if (far_wr && far_dest == src) begin
        sel = FWD_MEM_WB;
      end
    end
    return sel;
  endfunction

  assign opc      = if_id_i.inst[31:26];
  assign rs       = if_id_i.inst[25:21];
  assign rt       = if_id_i.inst[20:16];
  assign rd       = if_id_i.inst[15:11];
  assign funct    = if_id_i.inst[5:0];
  assign imm_sext = {{(XLEN-16){if_id_i.inst[15]}}, if_id_i.inst[15:0]};
  assign imm_zext = {{(XLEN-16){1'b0}}, if_id_i.inst[15:0]};

  assign rfile_rd_addr1_o = rs;
  assign rfile_rd_addr2_o = rt;

  // Unknown encodings fall through as no-ops
  always_comb begin
    alu_op    = ALU_ADD;
    imm       = imm_sext;
    imm_valid = 1'b0;
    load      = 1'b0;
    store     = 1'b0;
    a_used    = 1'b0;
    b_used    = 1'b0;
    dest      = rd;
    dest_ok   = 1'b0;
    case (opc)
      OPC_RTYPE: begin
        a_used  = 1'b1;
        b_used  = 1'b1;
        dest_ok = 1'b1;
        case (funct)
          FUNCT_ADD: alu_op = ALU_ADD;
          FUNCT_SUB: alu_op = ALU_SUB;
          FUNCT_AND: alu_op = ALU_AND;
          FUNCT_OR:  alu_op = ALU_OR;
          FUNCT_XOR: alu_op = ALU_XOR;
          FUNCT_SLT: alu_op = ALU_SLT;
          default: begin
            a_used  = 1'b0;
            b_used  = 1'b0;
            dest_ok = 1'b0;
          end
        endcase
      end
      OPC_ADDI, OPC_LW: begin
        a_used    = 1'b1;
        imm_valid = 1'b1;
        dest      = rt;
        dest_ok   = 1'b1;
        load      = (opc == OPC_LW);
      end
      OPC_ORI: begin
        alu_op    = ALU_OR;
        imm       = imm_zext;
        a_used    = 1'b1;
        imm_valid = 1'b1;
        dest      = rt;
        dest_ok   = 1'b1;
      end
      OPC_SW: begin
        a_used    = 1'b1;
        b_used    = 1'b1;
        imm_valid = 1'b1;
        store     = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // Load result is not ready until after MEM
  assign load_use = id_ex_o.valid && id_ex_o.load && id_ex_o.dest_valid &&
                    ((a_used && rs == id_ex_o.dest) || (b_used && rt == id_ex_o.dest));
  assign id_stall_o = if_id_i.valid && load_use;

  assign id_ex_d.valid      = if_id_i.valid;
  assign id_ex_d.a          = rfile_rd_data1_i;
  assign id_ex_d.b          = rfile_rd_data2_i;
  assign id_ex_d.imm        = imm;
  assign id_ex_d.imm_valid  = imm_valid;
  assign id_ex_d.alu_op     = alu_op;
  assign id_ex_d.a_fwd      = fwd_sel(a_used, rs, id_ex_o.valid && id_ex_o.dest_valid,
                                      id_ex_o.dest, ex_mem_i.valid && ex_mem_i.dest_valid,
                                      ex_mem_i.dest);
  assign id_ex_d.b_fwd      = fwd_sel(b_used, rt, id_ex_o.valid && id_ex_o.dest_valid,
                                      id_ex_o.dest, ex_mem_i.valid && ex_mem_i.dest_valid,
                                      ex_mem_i.dest);
  assign id_ex_d.load       = if_id_i.valid && load;
  assign id_ex_d.store      = if_id_i.valid && store;
  assign id_ex_d.dest       = dest;
  assign id_ex_d.dest_valid = if_id_i.valid && dest_ok && (dest != '0);

  pipe_stage_reg #(
    .payload_t (id_ex_t)
  ) id_ex_reg (
    .clock    (clock),
    .reset_i  (reset_i),
    .hold_i   (mem_stall_i),
    .bubble_i (id_stall_o),
    .d_i      (id_ex_d),
    .q_o      (id_ex_o)
  );

  // The producer picked one cycle earlier is now in EX/MEM, is no load, and is not r0
  ex_mem_fwd_live: assert property (
    @(posedge clock) disable iff (reset_i)
    id_ex_o.valid && (id_ex_o.a_fwd == FWD_EX_MEM || id_ex_o.b_fwd == FWD_EX_MEM)
    |-> ex_mem_i.valid && ex_mem_i.dest_valid && !ex_mem_i.load && ex_mem_i.dest != '0
  );

endmodule

//--- ifetch.sv
`timescale 1ns/1ps

module ifetch (
  input  logic                     clock,
  input  logic                     reset_i,
  input  logic                     stall_i,
  output logic [pip_pkg::XLEN-1:0] icache_addr_o,
  output logic                     icache_rd_o,
  input  logic [pip_pkg::XLEN-1:0] icache_data_i,
  input  logic                     icache_waitrequest_i,
  output pip_pkg::if_id_t          if_id_o
);

  import pip_pkg::*;

  logic [XLEN-1:0] pc;
  logic            run;
  logic            fetched;
  if_id_t          if_id_d;

  // Fetching starts one cycle after reset is released
  always_ff @(posedge clock) begin
    if (reset_i) begin
      run <= 1'b0;
      pc  <= RESET_PC;
    end else begin
      run <= 1'b1;
      if (fetched && !stall_i) begin
        pc <= pc + XLEN'(4);
      end
    end
  end

  assign icache_rd_o   = run;
  assign icache_addr_o = pc;

  // Word arrives in the cycle waitrequest is low
  assign fetched = run && !icache_waitrequest_i;

  assign if_id_d.valid = fetched;
  assign if_id_d.pc    = pc;
  assign if_id_d.inst  = icache_data_i;

  // On stall the word is dropped and fetched again
  pipe_stage_reg #(
    .payload_t (if_id_t)
  ) if_id_reg (
    .clock    (clock),
    .reset_i  (reset_i),
    .hold_i   (stall_i),
    .bubble_i (!fetched),
    .d_i      (if_id_d),
    .q_o      (if_id_o)
  );

endmodule

//--- mem.sv
`timescale 1ns/1ps

module mem (
  input  logic                           clock,
  input  logic                           reset_i,
  input  pip_pkg::ex_mem_t               ex_mem_i,
  output logic [pip_pkg::XLEN-1:0]       dcache_addr_o,
  output logic                           dcache_rd_o,
  output logic                           dcache_wr_o,
  output logic [pip_pkg::XLEN-1:0]       dcache_wr_data_o,
  output logic [pip_pkg::BE_W-1:0]       dcache_wr_be_o,
  input  logic [pip_pkg::XLEN-1:0]       dcache_data_i,
  input  logic                           dcache_waitrequest_i,
  output logic                           mem_stall_o,
  output pip_pkg::mem_wb_t               mem_wb_o,
  output logic [pip_pkg::REG_ADDR_W-1:0] rfile_wr_addr1_o,
  output logic                           rfile_wr_enable1_o,
  output logic [pip_pkg::XLEN-1:0]       rfile_wr_data1_o
);

  import pip_pkg::*;

  mem_wb_t mem_wb_d;

  assign dcache_rd_o      = ex_mem_i.valid && ex_mem_i.load;
  assign dcache_wr_o      = ex_mem_i.valid && ex_mem_i.store;
  assign dcache_addr_o    = ex_mem_i.result;
  assign dcache_wr_data_o = ex_mem_i.store_data;
  // Full-word stores only
  assign dcache_wr_be_o   = '1;

  assign mem_stall_o = (dcache_rd_o || dcache_wr_o) && dcache_waitrequest_i;

  assign mem_wb_d.valid      = ex_mem_i.valid;
  assign mem_wb_d.result     = ex_mem_i.load ? dcache_data_i : ex_mem_i.result;
  assign mem_wb_d.dest       = ex_mem_i.dest;
  assign mem_wb_d.dest_valid = ex_mem_i.dest_valid;

  pipe_stage_reg #(
    .payload_t (mem_wb_t)
  ) mem_wb_reg (
    .clock    (clock),
    .reset_i  (reset_i),
    .hold_i   (mem_stall_o),
    .bubble_i (1'b0),
    .d_i      (mem_wb_d),
    .q_o      (mem_wb_o)
  );

  // Held entry is written once, in the cycle the stall clears
  assign rfile_wr_addr1_o   = mem_wb_o.dest;
  assign rfile_wr_data1_o   = mem_wb_o.result;
  assign rfile_wr_enable1_o = mem_wb_o.valid && mem_wb_o.dest_valid && !mem_stall_o;

  dcache_rd_wr_excl: assert property (
    @(posedge clock) disable iff (reset_i)
    !(dcache_rd_o && dcache_wr_o)
  );

  // Request stays put until the cache accepts it
  dcache_req_stable: assert property (
    @(posedge clock) disable iff (reset_i)
    mem_stall_o |=> $stable(dcache_addr_o) && $stable(dcache_rd_o) &&
                    $stable(dcache_wr_o) && $stable(dcache_wr_data_o)
  );

endmodule

//--- pip_pkg.sv
package pip_pkg;

  // Datapath widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int BE_W       = XLEN / 8;

  localparam logic [XLEN-1:0] RESET_PC = '0;

  // Primary opcodes, inst[31:26]
  localparam logic [5:0] OPC_RTYPE = 6'h00;
  localparam logic [5:0] OPC_ADDI  = 6'h08;
  localparam logic [5:0] OPC_ORI   = 6'h0d;
  localparam logic [5:0] OPC_LW    = 6'h23;
  localparam logic [5:0] OPC_SW    = 6'h2b;

  // R-type function codes, inst[5:0]
  localparam logic [5:0] FUNCT_ADD = 6'h20;
  localparam logic [5:0] FUNCT_SUB = 6'h22;
  localparam logic [5:0] FUNCT_AND = 6'h24;
  localparam logic [5:0] FUNCT_OR  = 6'h25;
  localparam logic [5:0] FUNCT_XOR = 6'h26;
  localparam logic [5:0] FUNCT_SLT = 6'h2a;

  // Where execute takes an operand from
  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_EX_MEM,
    FWD_MEM_WB
  } fwd_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
  } if_id_t;

  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;
    logic [XLEN-1:0]       imm;
    logic                  imm_valid;
    alu_op_t               alu_op;
    fwd_t                  a_fwd;
    fwd_t                  b_fwd;
    logic                  load;
    logic                  store;
    logic [REG_ADDR_W-1:0] dest;
    logic                  dest_valid;
  } id_ex_t;

  // result is the ALU value, or the address for loads and stores
  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       result;
    logic [XLEN-1:0]       store_data;
    logic                  load;
    logic                  store;
    logic [REG_ADDR_W-1:0] dest;
    logic                  dest_valid;
  } ex_mem_t;

  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       result;
    logic [REG_ADDR_W-1:0] dest;
    logic                  dest_valid;
  } mem_wb_t;

endpackage

//--- pipe_stage_reg.sv
`timescale 1ns/1ps

module pipe_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     reset_i,
  input  logic     hold_i,
  input  logic     bubble_i,
  input  payload_t d_i,
  output payload_t q_o
);

  // Hold wins over bubble
  always_ff @(posedge clock) begin
    if (reset_i) begin
      q_o <= '0;
    end else if (!hold_i) begin
      if (bubble_i) begin
        q_o <= '0;
      end else begin
        q_o <= d_i;
      end
    end
  end

endmodule

//--- pipeline.sv
`timescale 1ns/1ps

module pipeline (
  input  logic                           clock,
  input  logic                           reset_i,

  // Instruction cache
  output logic [pip_pkg::XLEN-1:0]       icache_addr_o,
  output logic                           icache_rd_o,
  input  logic [pip_pkg::XLEN-1:0]       icache_data_i,
  input  logic                           icache_waitrequest_i,

  // Register file read ports
  output logic [pip_pkg::REG_ADDR_W-1:0] rfile_rd_addr1_o,
  output logic [pip_pkg::REG_ADDR_W-1:0] rfile_rd_addr2_o,
  input  logic [pip_pkg::XLEN-1:0]       rfile_rd_data1_i,
  input  logic [pip_pkg::XLEN-1:0]       rfile_rd_data2_i,

  // Data cache
  output logic [pip_pkg::XLEN-1:0]       dcache_addr_o,
  output logic                           dcache_rd_o,
  output logic                           dcache_wr_o,
  output logic [pip_pkg::XLEN-1:0]       dcache_wr_data_o,
  output logic [pip_pkg::BE_W-1:0]       dcache_wr_be_o,
  input  logic [pip_pkg::XLEN-1:0]       dcache_data_i,
  input  logic                           dcache_waitrequest_i,

  // Register file write port
  output logic [pip_pkg::REG_ADDR_W-1:0] rfile_wr_addr1_o,
  output logic                           rfile_wr_enable1_o,
  output logic [pip_pkg::XLEN-1:0]       rfile_wr_data1_o
);

  import pip_pkg::*;

  if_id_t  if_id;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  mem_wb_t mem_wb;

  logic    id_stall;
  logic    mem_stall;
  logic    if_stall;

  assign if_stall = mem_stall | id_stall;

  ifetch ifetch_inst (
    .clock                (clock),
    .reset_i              (reset_i),
    .stall_i              (if_stall),
    .icache_addr_o        (icache_addr_o),
    .icache_rd_o          (icache_rd_o),
    .icache_data_i        (icache_data_i),
    .icache_waitrequest_i (icache_waitrequest_i),
    .if_id_o              (if_id)
  );

  idec idec_inst (
    .clock            (clock),
    .reset_i          (reset_i),
    .mem_stall_i      (mem_stall),
    .if_id_i          (if_id),
    .ex_mem_i         (ex_mem),
    .rfile_rd_addr1_o (rfile_rd_addr1_o),
    .rfile_rd_addr2_o (rfile_rd_addr2_o),
    .rfile_rd_data1_i (rfile_rd_data1_i),
    .rfile_rd_data2_i (rfile_rd_data2_i),
    .id_stall_o       (id_stall),
    .id_ex_o          (id_ex)
  );

  ex ex_inst (
    .clock       (clock),
    .reset_i     (reset_i),
    .mem_stall_i (mem_stall),
    .id_ex_i     (id_ex),
    .mem_wb_i    (mem_wb),
    .ex_mem_o    (ex_mem)
  );

  mem mem_inst (
    .clock                (clock),
    .reset_i              (reset_i),
    .ex_mem_i             (ex_mem),
    .dcache_addr_o        (dcache_addr_o),
    .dcache_rd_o          (dcache_rd_o),
    .dcache_wr_o          (dcache_wr_o),
    .dcache_wr_data_o     (dcache_wr_data_o),
    .dcache_wr_be_o       (dcache_wr_be_o),
    .dcache_data_i        (dcache_data_i),
    .dcache_waitrequest_i (dcache_waitrequest_i),
    .mem_stall_o          (mem_stall),
    .mem_wb_o             (mem_wb),
    .rfile_wr_addr1_o     (rfile_wr_addr1_o),
    .rfile_wr_enable1_o   (rfile_wr_enable1_o),
    .rfile_wr_data1_o     (rfile_wr_data1_o)
  );

endmodule

//--- sources.f
pip_pkg.sv
pipe_stage_reg.sv
ifetch.sv
idec.sv
ex.sv
mem.sv
pipeline.sv
tb_pipeline.sv

//--- tb_pipeline.sv
`timescale 1ns/1ps

module tb_pipeline;

  import pip_pkg::*;

  localparam int          PROG_LEN   = 22;
  localparam int          QUIET      = 12;
  localparam int          WAIT_LIMIT = 2000;
  localparam int          DRAIN      = 20;
  localparam logic [31:0] SEED       = 32'hbb2a9ac7;

  logic                  clock = 1'b0;
  logic                  reset_i = 1'b1;
  logic                  icache_waitrequest_i = 1'b0;
  logic                  dcache_waitrequest_i = 1'b0;
  logic [XLEN-1:0]       icache_addr_o;
  logic                  icache_rd_o;
  logic [XLEN-1:0]       icache_data_i;
  logic [REG_ADDR_W-1:0] rfile_rd_addr1_o;
  logic [REG_ADDR_W-1:0] rfile_rd_addr2_o;
  logic [XLEN-1:0]       rfile_rd_data1_i;
  logic [XLEN-1:0]       rfile_rd_data2_i;
  logic [XLEN-1:0]       dcache_addr_o;
  logic                  dcache_rd_o;
  logic                  dcache_wr_o;
  logic [XLEN-1:0]       dcache_wr_data_o;
  logic [BE_W-1:0]       dcache_wr_be_o;
  logic [XLEN-1:0]       dcache_data_i;
  logic [REG_ADDR_W-1:0] rfile_wr_addr1_o;
  logic                  rfile_wr_enable1_o;
  logic [XLEN-1:0]       rfile_wr_data1_o;

  logic [31:0]           prog [0:31];
  logic [31:0]           dmem [0:63];
  logic [31:0]           model_mem [0:63];
  logic [31:0]           rf [0:31];
  logic [REG_ADDR_W-1:0] exp_reg [0:63];
  logic [31:0]           exp_val [0:63];
  logic [31:0]           exp_st_addr [0:63];
  logic [31:0]           exp_st_data [0:63];
  int                    n_exp_wr = 0;
  int                    n_exp_st = 0;

  int          wr_idx = 0;
  int          st_idx = 0;
  int          cycles = 0;
  logic        rst_d = 1'b1;
  logic        fetch_seen = 1'b0;
  logic [31:0] lfsr = SEED;

  int err_reset = 0;
  int err_fetch = 0;
  int err_wr = 0;
  int err_extra = 0;
  int err_st = 0;
  int err_hs = 0;
  int err_r0 = 0;
  int err_end = 0;

  pipeline pipeline_inst (
    .clock                (clock),
    .reset_i              (reset_i),
    .icache_addr_o        (icache_addr_o),
    .icache_rd_o          (icache_rd_o),
    .icache_data_i        (icache_data_i),
    .icache_waitrequest_i (icache_waitrequest_i),
    .rfile_rd_addr1_o     (rfile_rd_addr1_o),
    .rfile_rd_addr2_o     (rfile_rd_addr2_o),
    .rfile_rd_data1_i     (rfile_rd_data1_i),
    .rfile_rd_data2_i     (rfile_rd_data2_i),
    .dcache_addr_o        (dcache_addr_o),
    .dcache_rd_o          (dcache_rd_o),
    .dcache_wr_o          (dcache_wr_o),
    .dcache_wr_data_o     (dcache_wr_data_o),
    .dcache_wr_be_o       (dcache_wr_be_o),
    .dcache_data_i        (dcache_data_i),
    .dcache_waitrequest_i (dcache_waitrequest_i),
    .rfile_wr_addr1_o     (rfile_wr_addr1_o),
    .rfile_wr_enable1_o   (rfile_wr_enable1_o),
    .rfile_wr_data1_o     (rfile_wr_data1_o)
  );

  function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rd,
                                        input logic [4:0] rs, input logic [4:0] rt);
    return {OPC_RTYPE, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] opc, input logic [4:0] rt,
                                        input logic [4:0] rs, input logic [15:0] imm);
    return {opc, rs, rt, imm};
  endfunction

  // Initial memory word from the full byte address
  function automatic logic [31:0] mem_fill(input logic [31:0] addr);
    return 32'h5a5a_0000 ^ (addr * 32'h0100_0193);
  endfunction

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // In-order ISA model producing the expected writes and stores
  task automatic run_model();
    logic [31:0] regs [0:31];
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] addr;
    logic [31:0] val;
    logic [4:0]  dst;
    logic        wr;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      inst = prog[i];
      a    = regs[inst[25:21]];
      b    = regs[inst[20:16]];
      simm = {{16{inst[15]}}, inst[15:0]};
      addr = a + simm;
      wr   = 1'b1;
      dst  = inst[20:16];
      val  = '0;
      case (inst[31:26])
        OPC_RTYPE: begin
          dst = inst[15:11];
          case (inst[5:0])
            FUNCT_ADD: val = a + b;
            FUNCT_SUB: val = a - b;
            FUNCT_AND: val = a & b;
            FUNCT_OR:  val = a | b;
            FUNCT_XOR: val = a ^ b;
            FUNCT_SLT: val = {31'd0, $signed(a) < $signed(b)};
            default:   wr = 1'b0;
          endcase
        end
        OPC_ADDI: val = a + simm;
        OPC_ORI:  val = a | {16'd0, inst[15:0]};
        OPC_LW:   val = model_mem[addr[7:2]];
        OPC_SW: begin
          wr = 1'b0;
          exp_st_addr[n_exp_st] = addr;
          exp_st_data[n_exp_st] = b;
          model_mem[addr[7:2]] = b;
          n_exp_st++;
        end
        default: wr = 1'b0;
      endcase
      if (wr && dst != 5'd0) begin
        regs[dst] = val;
        exp_reg[n_exp_wr] = dst;
        exp_val[n_exp_wr] = val;
        n_exp_wr++;
      end
    end
  endtask

  initial begin
    for (int i = 0; i < 32; i++) begin
      prog[i] = '0;
      rf[i]   = '0;
    end
    for (int i = 0; i < 64; i++) begin
      dmem[i]      = mem_fill(32'(i) << 2);
      model_mem[i] = mem_fill(32'(i) << 2);
    end
    prog[0]  = enc_i(OPC_ADDI, 5'd1, 5'd0, 16'd5);
    prog[1]  = enc_i(OPC_ADDI, 5'd2, 5'd0, 16'hfffd);
    prog[2]  = enc_r(FUNCT_ADD, 5'd3, 5'd1, 5'd2);
    prog[3]  = enc_r(FUNCT_SUB, 5'd4, 5'd3, 5'd1);
    prog[4]  = enc_r(FUNCT_AND, 5'd5, 5'd4, 5'd3);
    prog[5]  = enc_r(FUNCT_OR, 5'd6, 5'd5, 5'd2);
    prog[6]  = enc_r(FUNCT_XOR, 5'd7, 5'd6, 5'd1);
    prog[7]  = enc_r(FUNCT_SLT, 5'd8, 5'd2, 5'd1);
    prog[8]  = enc_i(OPC_ORI, 5'd9, 5'd0, 16'hf0f0);
    prog[9]  = enc_i(OPC_ORI, 5'd10, 5'd2, 16'h8000);
    prog[10] = enc_i(OPC_SW, 5'd9, 5'd0, 16'd8);
    prog[11] = enc_i(OPC_LW, 5'd11, 5'd0, 16'd8);
    // Load-use pairs
    prog[12] = enc_r(FUNCT_ADD, 5'd12, 5'd11, 5'd1);
    prog[13] = enc_i(OPC_LW, 5'd13, 5'd1, 16'd11);
    prog[14] = enc_r(FUNCT_SUB, 5'd14, 5'd13, 5'd12);
    prog[15] = enc_i(OPC_ADDI, 5'd0, 5'd1, 16'd7);
    prog[16] = enc_r(FUNCT_ADD, 5'd15, 5'd0, 5'd1);
    prog[17] = enc_i(OPC_SW, 5'd14, 5'd1, 16'd19);
    prog[18] = enc_i(OPC_LW, 5'd16, 5'd0, 16'd24);
    prog[19] = enc_r(FUNCT_XOR, 5'd17, 5'd16, 5'd14);
    prog[20] = enc_r(FUNCT_ADD, 5'd0, 5'd1, 5'd1);
    prog[21] = enc_r(FUNCT_SLT, 5'd18, 5'd1, 5'd2);
    run_model();
  end

  initial begin
    forever #4 clock = ~clock;
  end

  // Cache and register file models
  assign icache_data_i = (icache_addr_o[31:2] < 30'(PROG_LEN)) ? prog[icache_addr_o[6:2]] : '0;
  assign dcache_data_i = dmem[dcache_addr_o[7:2]];

  assign rfile_rd_data1_i = (rfile_rd_addr1_o == '0) ? '0 :
                            (rfile_wr_enable1_o && rfile_wr_addr1_o == rfile_rd_addr1_o) ?
                            rfile_wr_data1_o : rf[rfile_rd_addr1_o];
  assign rfile_rd_data2_i = (rfile_rd_addr2_o == '0) ? '0 :
                            (rfile_wr_enable1_o && rfile_wr_addr1_o == rfile_rd_addr2_o) ?
                            rfile_wr_data1_o : rf[rfile_rd_addr2_o];

  always @(posedge clock) begin
    if (rfile_wr_enable1_o) begin
      rf[rfile_wr_addr1_o] <= rfile_wr_data1_o;
    end
    if (!reset_i && dcache_wr_o && !dcache_waitrequest_i) begin
      dmem[dcache_addr_o[7:2]] <= dcache_wr_data_o;
    end
  end

  // Random waitrequest after a quiet start
  always @(posedge clock) begin
    logic [31:0] s;
    logic [3:0]  bits;
    s = lfsr;
    for (int k = 0; k < 4; k++) begin
      bits[k] = s[0];
      s = lfsr_step(s);
    end
    if (reset_i || cycles < QUIET) begin
      icache_waitrequest_i <= 1'b0;
      dcache_waitrequest_i <= 1'b0;
    end else begin
      lfsr = s;
      icache_waitrequest_i <= bits[0] & bits[1];
      dcache_waitrequest_i <= bits[2] & bits[3];
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    rst_d  <= reset_i;
    if (!reset_i && rfile_wr_enable1_o) begin
      wr_idx <= wr_idx + 1;
    end
    if (!reset_i && dcache_wr_o && !dcache_waitrequest_i) begin
      st_idx <= st_idx + 1;
    end
    if (!reset_i && icache_rd_o && !icache_waitrequest_i) begin
      fetch_seen <= 1'b1;
    end
  end

  reset_quiet: assert property (
    @(posedge clock) (cycles > 0) && (reset_i || rst_d)
    |-> !icache_rd_o && !dcache_rd_o && !dcache_wr_o && !rfile_wr_enable1_o
  ) else begin
    $write("[FAIL] %0t icache_rd_o=%b dcache_rd_o=%b ", $time, $sampled(icache_rd_o),
           $sampled(dcache_rd_o));
    $display("dcache_wr_o=%b rfile_wr_enable1_o=%b expected all 0", $sampled(dcache_wr_o),
             $sampled(rfile_wr_enable1_o));
    err_reset++;
  end

  first_fetch: assert property (
    @(posedge clock) disable iff (reset_i)
    icache_rd_o && !icache_waitrequest_i && !fetch_seen |-> icache_addr_o == RESET_PC
  ) else begin
    $display("[FAIL] %0t icache_addr_o: got %h expected %h", $time,
             $sampled(icache_addr_o), RESET_PC);
    err_fetch++;
  end

  wr_extra: assert property (
    @(posedge clock) disable iff (reset_i)
    rfile_wr_enable1_o |-> wr_idx < n_exp_wr
  ) else begin
    $display("%0t register write beyond the expected count", $time);
    err_extra++;
  end

  wr_match: assert property (
    @(posedge clock) disable iff (reset_i)
    rfile_wr_enable1_o && wr_idx < n_exp_wr
    |-> rfile_wr_addr1_o == exp_reg[wr_idx] && rfile_wr_data1_o == exp_val[wr_idx]
  ) else begin
    $display("[FAIL] %0t rfile_wr_addr1_o/rfile_wr_data1_o: got r%0d=%h expected r%0d=%h",
             $time, $sampled(rfile_wr_addr1_o), $sampled(rfile_wr_data1_o),
             exp_reg[$sampled(wr_idx)], exp_val[$sampled(wr_idx)]);
    err_wr++;
  end

  st_match: assert property (
    @(posedge clock) disable iff (reset_i)
    dcache_wr_o && !dcache_waitrequest_i
    |-> st_idx < n_exp_st && dcache_addr_o == exp_st_addr[st_idx] &&
        dcache_wr_data_o == exp_st_data[st_idx] && dcache_wr_be_o == 4'hf
  ) else begin
    $display("[FAIL] %0t dcache_addr_o/dcache_wr_data_o: got %h/%h be %h expected %h/%h",
             $time, $sampled(dcache_addr_o), $sampled(dcache_wr_data_o),
             $sampled(dcache_wr_be_o), exp_st_addr[$sampled(st_idx)],
             exp_st_data[$sampled(st_idx)]);
    err_st++;
  end

  dcache_hold: assert property (
    @(posedge clock) disable iff (reset_i)
    (dcache_rd_o || dcache_wr_o) && dcache_waitrequest_i
    |=> $stable(dcache_addr_o) && $stable(dcache_rd_o) && $stable(dcache_wr_o) &&
        $stable(dcache_wr_data_o)
  ) else begin
    $display("%0t dcache request changed while waitrequest was high", $time);
    err_hs++;
  end

  dcache_excl: assert property (
    @(posedge clock) disable iff (reset_i)
    !(dcache_rd_o && dcache_wr_o)
  ) else begin
    $display("%0t dcache_rd_o and dcache_wr_o were high together", $time);
    err_hs++;
  end

  r0_never: assert property (
    @(posedge clock) disable iff (reset_i)
    rfile_wr_enable1_o |-> rfile_wr_addr1_o != '0
  ) else begin
    $display("%0t register 0 was written", $time);
    err_r0++;
  end

  initial begin
    int timer;
    int total;
    repeat (4) @(posedge clock);
    reset_i <= 1'b0;
    timer = 0;
    while (wr_idx < n_exp_wr && timer < WAIT_LIMIT) begin
      @(posedge clock);
      timer++;
    end
    if (wr_idx < n_exp_wr) begin
      $display("timeout waiting for register writes, saw %0d of %0d", wr_idx, n_exp_wr);
      err_end++;
    end else begin
      // Let the tail of the pipe drain to catch stray writes
      timer = 0;
      while (timer < DRAIN) begin
        @(posedge clock);
        timer++;
      end
      if (st_idx != n_exp_st) begin
        $display("store count mismatch, saw %0d of %0d", st_idx, n_exp_st);
        err_end++;
      end
    end
    total = err_reset + err_fetch + err_wr + err_extra + err_st + err_hs + err_r0 + err_end;
    $display("errors: reset=%0d fetch=%0d wr=%0d extra=%0d st=%0d hs=%0d r0=%0d end=%0d",
             err_reset, err_fetch, err_wr, err_extra, err_st, err_hs, err_r0, err_end);
    if (total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
